// ==== emmu.sv ====
`timescale 1ns/10ps

// translation stage
// dstaddr[31:20] indexes the table, the entry widens the address to 64 bits
// one cycle from access in to access out
module emmu #(
   parameter int MAW = 12                         // table address width
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      mmu_en,      // translate when set
   input  logic                      mmu_bp,      // bypass, e.g. read response
   input  logic                      emesh_access_in,
   input  logic [emmu_pkg::PW-1:0]   emesh_packet_in,
   input  logic                      emesh_wait_in,    // downstream pushback
   input  logic [emmu_pkg::MW-1:0]   tbl_rd_data,
   output logic                      tbl_rd_en,
   output logic [MAW-1:0]            tbl_rd_addr,
   output logic                      emesh_access_out,
   output logic [emmu_pkg::PW-1:0]   emesh_packet_out,
   output logic [31:0]               emesh_packet_hi_out
);

   logic                      accept;             // packet taken this cycle
   logic                      xlate;              // translation active
   logic [emmu_pkg::PW-1:0]   emesh_packet_reg;
   logic [63:0]               dstaddr_out;        // rebuilt address
   emmu_pkg::emmu_entry_u     lookup;             // entry as translation sees it

   assign accept = emesh_access_in & ~emesh_wait_in;

   // lookup issued with the packet, data arrives in the output cycle
   assign tbl_rd_en   = accept;                   // keeps ram data aligned with held packet
   assign tbl_rd_addr = emesh_packet_in[emmu_pkg::IDX_LSB +: MAW];   // upper bits ignored

   // access pipe, frozen by wait
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         emesh_access_out <= 1'b0;
      else if (~emesh_wait_in)
         emesh_access_out <= emesh_access_in;
   end

   // packet payload, no reset
   always_ff @(posedge clk) begin
      if (accept)
         emesh_packet_reg <= emesh_packet_in;
   end

   assign lookup = tbl_rd_data;
   assign xlate  = mmu_en & ~mmu_bp;

   // 44 bit extension + low 20 address bits, or plain 32 bit address
   always_comb begin
      if (xlate)
         dstaddr_out = {lookup.addr.ext,
                        emesh_packet_reg[emmu_pkg::IDX_LSB-1:emmu_pkg::ADDR_LSB]};
      else
         dstaddr_out = {32'b0,
                        emesh_packet_reg[emmu_pkg::ADDR_MSB:emmu_pkg::ADDR_LSB]};
   end

   // rebuild the packet around the new address
   assign emesh_packet_out = {emesh_packet_reg[emmu_pkg::PW-1:emmu_pkg::ADDR_MSB+1],
                              dstaddr_out[31:0],
                              emesh_packet_reg[emmu_pkg::ADDR_LSB-1:0]};

   assign emesh_packet_hi_out = dstaddr_out[63:32];    // zero in bypass

   // wait holds the output transaction, valid or not
   a_wait_hold : assert property (
      @(posedge clk) disable iff (reset)
      emesh_wait_in |=> $stable(emesh_access_out) &&
                        (!emesh_access_out ||
                         ($stable(emesh_packet_out) && $stable(emesh_packet_hi_out)))
   ) else $error("emmu: output moved under wait");

endmodule

// ==== emmu_cfg.sv ====
`timescale 1ns/10ps

// mi decoder
// table half writes, enable register and its readback
// the clear sequencer owns the table write port while busy
module emmu_cfg #(
   parameter int MAW = 12                         // table address width
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      mi_en,       // single cycle access
   input  logic                      mi_we,       // write, else read
   input  logic [19:0]               mi_addr,
   input  logic [emmu_pkg::DW-1:0]   mi_din,
   input  logic                      scrub_we,
   input  logic [MAW-1:0]            scrub_addr,
   input  logic                      scrub_busy,
   output logic [emmu_pkg::DW-1:0]   mi_dout,
   output logic                      mmu_en,      // control bit 0
   output logic [5:0]                tbl_wr_en,   // byte enables to ram
   output logic [MAW-1:0]            tbl_wr_addr,
   output logic [emmu_pkg::MW-1:0]   tbl_wr_data
);

   logic                  ctrl_sel;    // control register selected
   logic                  tbl_wr;      // mi table write, any half
   logic                  lo_we;       // bytes 3:0
   logic                  hi_we;       // bytes 5:4
   logic                  ctrl_we;
   logic                  ctrl_rd;
   emmu_pkg::emmu_entry_u mi_entry;    // entry as the mi port sees it

   // address decode
   assign ctrl_sel = mi_addr[emmu_pkg::CTRL_SEL_BIT];
   assign ctrl_we  = mi_en &  mi_we & ctrl_sel;
   assign ctrl_rd  = mi_en & ~mi_we & ctrl_sel;
   assign tbl_wr   = mi_en &  mi_we & ~ctrl_sel & ~scrub_busy;   // dropped while clearing
   assign lo_we    = tbl_wr & ~mi_addr[2];
   assign hi_we    = tbl_wr &  mi_addr[2];

   // same mi word lands on whichever half is enabled
   always_comb begin
      mi_entry.word.lo = mi_din;
      mi_entry.word.hi = mi_din[15:0];                  // upper 16 bits of din unused
   end

   // write port mux, zero cycle to the ram
   always_comb begin
      if (scrub_busy) begin
         tbl_wr_en   = {6{scrub_we}};                   // whole entry
         tbl_wr_addr = scrub_addr;
         tbl_wr_data = '0;
      end else begin
         tbl_wr_en   = {{emmu_pkg::HI_BYTES{hi_we}}, {emmu_pkg::LO_BYTES{lo_we}}};
         tbl_wr_addr = mi_addr[3 +: MAW];               // entry index from bit 3 up
         tbl_wr_data = mi_entry;
      end
   end

   // enable register, off after reset so packets bypass
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         mmu_en <= 1'b0;
      else if (ctrl_we)
         mmu_en <= mi_din[0];
   end

   // readback, one cycle after the read strobe
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         mi_dout <= '0;
      else if (ctrl_rd)
         mi_dout <= {{(emmu_pkg::DW-1){1'b0}}, mmu_en};
   end

   // once the clear is over, mi only ever writes one half at a time
   a_one_half : assert property (
      @(posedge clk) disable iff (reset)
      !scrub_busy |-> !((|tbl_wr_en[3:0]) && (|tbl_wr_en[5:4]))
   ) else $error("emmu_cfg: both table halves written at once");

endmodule

// ==== emmu_pkg.sv ====
// shared constants and the table entry layout for the emmu subsystem
package emmu_pkg;

   // packet and bus widths
   localparam int PW = 104;           // emesh packet width
   localparam int DW = 32;            // mi data width
   localparam int MW = 48;            // table entry width, 6 bytes

   // destination address field inside the packet
   localparam int ADDR_LSB = 8;       // dstaddr bit 0
   localparam int ADDR_MSB = 39;      // dstaddr bit 31

   // dstaddr[31:20] sits at packet bits 39:28
   localparam int IDX_LSB = 28;       // first index bit in the packet

   // mi address bit that picks the control register over the table
   localparam int CTRL_SEL_BIT = 19;

   // one table entry, two views of the same 48 bits
   // mi writes it as two register words
   // translation reads it as the upper address bits
   typedef union packed {
      struct packed {
         logic [15:0] hi;            // bytes 5:4, second mi write
         logic [31:0] lo;            // bytes 3:0, first mi write
      } word;
      struct packed {
         logic [3:0]  rsvd;          // never looked at
         logic [43:0] ext;           // replaces dstaddr[31:20]
      } addr;
   } emmu_entry_u;

   // byte lanes per half, handy for the write enable vector
   localparam int LO_BYTES = 4;
   localparam int HI_BYTES = 2;

endpackage

// ==== emmu_scrub.sv ====
`timescale 1ns/10ps

// post reset table clear
// walks every entry once, one write per cycle, then parks in DONE
module emmu_scrub #(
   parameter int MAW = 12                  // table address width
) (
   input  logic            clk,
   input  logic            reset,
   output logic            scrub_we,       // clear write strobe
   output logic [MAW-1:0]  scrub_addr,     // entry being cleared
   output logic            scrub_busy      // table still being cleared
);

   // state encoding
   localparam logic CLEAR = 1'b0;
   localparam logic DONE  = 1'b1;

   logic            state;
   logic [MAW-1:0]  entry_cnt;             // next entry to clear
   logic            last_entry;            // counter about to wrap

   assign last_entry = &entry_cnt;

   // fsm and entry counter together
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state     <= CLEAR;
         entry_cnt <= '0;
      end else begin
         case (state)
            CLEAR: begin
               entry_cnt <= entry_cnt + 1'b1;    // wraps to 0 at the end
               if (last_entry)
                  state <= DONE;
            end
            DONE: begin
               entry_cnt <= entry_cnt;           // parked
            end
            default: begin
               state <= CLEAR;
            end
         endcase
      end
   end

   // outputs straight from state, write data is zero at the decoder
   assign scrub_we   = (state == CLEAR);
   assign scrub_addr = entry_cnt;
   assign scrub_busy = (state == CLEAR);

   // DONE is terminal until the next reset
   // so the clear never stomps on a configured table
   a_done_sticky : assert property (
      @(posedge clk) disable iff (reset)
      (state == DONE) |=> (state == DONE) && !scrub_we
   ) else $error("emmu_scrub: clear write after DONE");

endmodule

// ==== emmu_tb.sv ====
`timescale 1ns/10ps

module emmu_tb;

   localparam int MAW          = 6;                     // small table, short clear
   localparam int PW           = emmu_pkg::PW;
   localparam int DW           = emmu_pkg::DW;
   localparam int ADDR_LSB     = emmu_pkg::ADDR_LSB;
   localparam int ADDR_MSB     = emmu_pkg::ADDR_MSB;
   localparam int IDX_LSB      = emmu_pkg::IDX_LSB;
   localparam int CTRL_BIT     = emmu_pkg::CTRL_SEL_BIT;
   localparam int CLK_PERIOD   = 20;
   localparam int ENTRIES      = 2**MAW;
   localparam int NPKT         = 20 + 20 + ENTRIES + 100 + 100;  // all phases
   localparam int WATCHDOG_CYC = ENTRIES + NPKT*4 + 200;

   logic            clk;
   logic            reset;
   logic            mmu_bp;
   logic            mi_en;
   logic            mi_we;
   logic [19:0]     mi_addr;
   logic [DW-1:0]   mi_din;
   logic            emesh_access_in;
   logic [PW-1:0]   emesh_packet_in;
   logic            emesh_wait_in;
   logic [DW-1:0]   mi_dout;
   logic            scrub_busy;
   logic            emesh_access_out;
   logic [PW-1:0]   emesh_packet_out;
   logic [31:0]     emesh_packet_hi_out;

   // reference model state
   emmu_pkg::emmu_entry_u shadow [0:ENTRIES-1];        // mirror of the table
   logic            shadow_en;
   logic            exp_access;
   logic [PW-1:0]   exp_pkt;
   logic [31:0]     exp_hi;
   logic [DW-1:0]   exp_dout;
   int              cyc_cnt;                           // edges since reset release
   int              n_accepted;
   int              n_delivered;
   logic            stall_mode;                        // random wait levels on
   integer          seed;
   logic [MAW-1:0]  wr_idx;

   emmu_top #(.MAW(MAW)) DUT (
      .clk                 (clk),
      .reset               (reset),
      .mmu_bp              (mmu_bp),
      .mi_en               (mi_en),
      .mi_we               (mi_we),
      .mi_addr             (mi_addr),
      .mi_din              (mi_din),
      .emesh_access_in     (emesh_access_in),
      .emesh_packet_in     (emesh_packet_in),
      .emesh_wait_in       (emesh_wait_in),
      .mi_dout             (mi_dout),
      .scrub_busy          (scrub_busy),
      .emesh_access_out    (emesh_access_out),
      .emesh_packet_out    (emesh_packet_out),
      .emesh_packet_hi_out (emesh_packet_hi_out)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string msg);
      $display("FAIL at %0t ns: %s", $time, msg);
      abort_run();
   endtask

   // expected {hi word, packet} for one packet, straight from the address rule
   function automatic logic [PW+31:0] translate_ref(input logic [PW-1:0] pkt,
                                                    input logic on,
                                                    input emmu_pkg::emmu_entry_u ent);
      logic [63:0]   full;
      logic [PW-1:0] p;
      p    = pkt;
      full = '0;
      if (on) begin
         full = {ent.addr.ext, pkt[IDX_LSB-1:ADDR_LSB]};   // 44 + 20 bits
         p[ADDR_MSB:ADDR_LSB] = full[31:0];
      end
      return {full[63:32], p};
   endfunction

   function automatic logic [PW-1:0] rand_packet();
      logic [127:0] r;
      for (int w = 0; w < 4; w++)
         r[32*w +: 32] = $random(seed);
      return r[PW-1:0];
   endfunction

   assign wr_idx = mi_addr[3 +: MAW];

   // model, one packet in flight, table writes visible the cycle after
   always @(posedge clk or posedge reset) begin
      if (reset) begin
         exp_access <= 1'b0;
         exp_dout   <= '0;
         shadow_en  <= 1'b0;
         cyc_cnt    <= 0;
         n_accepted <= 0;
      end else begin
         cyc_cnt <= cyc_cnt + 1;
         if (!emesh_wait_in)
            exp_access <= emesh_access_in;
         if (emesh_access_in && !emesh_wait_in) begin
            {exp_hi, exp_pkt} <= translate_ref(emesh_packet_in, shadow_en && !mmu_bp,
                                               shadow[emesh_packet_in[IDX_LSB +: MAW]]);
            n_accepted <= n_accepted + 1;
         end
         if (mi_en && mi_we && mi_addr[CTRL_BIT])
            shadow_en <= mi_din[0];
         if (mi_en && !mi_we && mi_addr[CTRL_BIT])
            exp_dout <= {{(DW-1){1'b0}}, shadow_en};
         // table writes only count once the clear is over
         if (mi_en && mi_we && !mi_addr[CTRL_BIT] && cyc_cnt >= ENTRIES) begin
            if (mi_addr[2])
               shadow[wr_idx].word.hi <= mi_din[15:0];
            else
               shadow[wr_idx].word.lo <= mi_din;
         end
      end
   end

   always @(posedge clk) begin
      if (!reset && emesh_access_out && !emesh_wait_in)
         n_delivered <= n_delivered + 1;            // taken by downstream
   end

   a_clear_time : assert property (@(posedge clk) disable iff (reset)
      scrub_busy === (cyc_cnt < ENTRIES))
      else report_mismatch($sformatf("scrub_busy %b at cycle %0d", $sampled(scrub_busy),
                                     $sampled(cyc_cnt)));

   a_access : assert property (@(posedge clk) disable iff (reset)
      emesh_access_out === exp_access)
      else report_mismatch("emesh_access_out differs from model");

   a_packet : assert property (@(posedge clk) disable iff (reset)
      exp_access |-> (emesh_packet_out === exp_pkt) && (emesh_packet_hi_out === exp_hi))
      else report_mismatch($sformatf("packet %h hi %h, expected %h hi %h",
                                     $sampled(emesh_packet_out), $sampled(emesh_packet_hi_out),
                                     $sampled(exp_pkt), $sampled(exp_hi)));

   a_readback : assert property (@(posedge clk) disable iff (reset)
      mi_dout === exp_dout)
      else report_mismatch($sformatf("mi_dout %h expected %h", $sampled(mi_dout),
                                     $sampled(exp_dout)));

   a_hold : assert property (@(posedge clk) disable iff (reset)
      emesh_wait_in && emesh_access_out |=> emesh_access_out &&
         $stable(emesh_packet_out) && $stable(emesh_packet_hi_out))
      else report_mismatch("output moved while wait was high");

   task automatic idle_cycles(input int n);
      repeat (n) begin
         emesh_access_in = 1'b0;
         emesh_wait_in   = stall_mode ? (($random(seed) & 3) < 2) : 1'b0;
         @(posedge clk);
         #2;
      end
   endtask

   // holds access and packet until a cycle with wait low
   task automatic send_packet(input logic [PW-1:0] pkt);
      logic taken;
      taken           = 1'b0;
      emesh_access_in = 1'b1;
      emesh_packet_in = pkt;
      while (!taken) begin
         emesh_wait_in = stall_mode ? (($random(seed) & 3) < 2) : 1'b0;
         @(posedge clk);
         taken = !emesh_wait_in;
         #2;
      end
      emesh_access_in = 1'b0;
   endtask

   task automatic mi_write(input logic [19:0] addr, input logic [DW-1:0] data);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = addr;
      mi_din  = data;
      @(posedge clk);
      #2;
      mi_en = 1'b0;
      mi_we = 1'b0;
   endtask

   task automatic ctrl_read();
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = 20'h1 << CTRL_BIT;
      @(posedge clk);
      #2;
      mi_en = 1'b0;
      idle_cycles(1);                               // let readback get checked
   endtask

   task automatic send_random(input int n);
      repeat (n) begin
         send_packet(rand_packet());
         if (stall_mode)
            idle_cycles($unsigned($random(seed)) % 2);
      end
      idle_cycles(2);                               // drain before any mode change
   endtask

   initial begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("ERROR: run timed out after %0d clock cycles", WATCHDOG_CYC);
      abort_run();
   end

   initial begin
      logic [PW-1:0] pkt;
      seed            = 50963;
      clk             = 1'b0;
      reset           = 1'b1;
      mmu_bp          = 1'b0;
      mi_en           = 1'b0;
      mi_we           = 1'b0;
      mi_addr         = '0;
      mi_din          = '0;
      emesh_access_in = 1'b0;
      emesh_packet_in = '0;
      emesh_wait_in   = 1'b0;
      stall_mode      = 1'b0;
      n_delivered     = 0;
      for (int i = 0; i < ENTRIES; i++)
         shadow[i] = '0;                            // clear leaves zeros
      repeat (2) @(posedge clk);
      #2;
      reset = 1'b0;

      // during the clear, readback 0 and a write to an entry
      // the clear already passed, which must be dropped
      ctrl_read();
      mi_write(20'd1 << 3, 32'hdead_beef);
      while (scrub_busy) begin
         @(posedge clk);
         #2;
      end

      send_random(20);                              // enable 0, bypass
      mi_write(20'h1 << CTRL_BIT, 32'h1);
      mmu_bp = 1'b1;
      idle_cycles(1);
      send_random(20);                              // bp high, bypass
      mmu_bp = 1'b0;
      ctrl_read();

      // every index once, table still all zero
      for (int i = 0; i < ENTRIES; i++) begin
         pkt = rand_packet();
         pkt[IDX_LSB +: MAW] = i;
         send_packet(pkt);
      end
      idle_cycles(2);

      for (int i = 0; i < ENTRIES; i++) begin
         mi_write(20'(i) << 3, $random(seed));              // low word
         mi_write((20'(i) << 3) | 20'h4, $random(seed));    // high 16 bits
      end
      mi_write(20'h1 << CTRL_BIT, 32'h0);
      ctrl_read();
      mi_write(20'h1 << CTRL_BIT, 32'h1);
      ctrl_read();
      send_random(100);

      stall_mode = 1'b1;
      send_random(100);
      stall_mode    = 1'b0;
      emesh_wait_in = 1'b0;
      idle_cycles(3);

      if (n_accepted != NPKT || n_delivered != NPKT)
         report_mismatch($sformatf("accepted %0d delivered %0d, expected %0d",
                                   n_accepted, n_delivered, NPKT));
      else begin
         $display("TEST OK");
         $finish;
      end
   end

endmodule

// ==== emmu_top.sv ====
`timescale 1ns/10ps

// address translation subsystem top
// clear sequencer, mi decoder, table ram and translation stage
module emmu_top #(
   parameter int MAW = 12                         // table address width
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      mmu_bp,
   input  logic                      mi_en,
   input  logic                      mi_we,
   input  logic [19:0]               mi_addr,
   input  logic [emmu_pkg::DW-1:0]   mi_din,
   input  logic                      emesh_access_in,
   input  logic [emmu_pkg::PW-1:0]   emesh_packet_in,
   input  logic                      emesh_wait_in,
   output logic [emmu_pkg::DW-1:0]   mi_dout,
   output logic                      scrub_busy,
   output logic                      emesh_access_out,
   output logic [emmu_pkg::PW-1:0]   emesh_packet_out,
   output logic [31:0]               emesh_packet_hi_out
);

   // clear sequencer to decoder
   logic                      scrub_we;
   logic [MAW-1:0]            scrub_addr;

   // decoder to translation
   logic                      mmu_en;

   // table write port
   logic [5:0]                tbl_wr_en;
   logic [MAW-1:0]            tbl_wr_addr;
   logic [emmu_pkg::MW-1:0]   tbl_wr_data;

   // table read port
   logic                      tbl_rd_en;
   logic [MAW-1:0]            tbl_rd_addr;
   logic [emmu_pkg::MW-1:0]   tbl_rd_data;

   emmu_scrub #(.MAW(MAW)) u_scrub (
      .clk         (clk),
      .reset       (reset),
      .scrub_we    (scrub_we),
      .scrub_addr  (scrub_addr),
      .scrub_busy  (scrub_busy)
   );

   emmu_cfg #(.MAW(MAW)) u_cfg (
      .clk         (clk),
      .reset       (reset),
      .mi_en       (mi_en),
      .mi_we       (mi_we),
      .mi_addr     (mi_addr),
      .mi_din      (mi_din),
      .scrub_we    (scrub_we),
      .scrub_addr  (scrub_addr),
      .scrub_busy  (scrub_busy),
      .mi_dout     (mi_dout),
      .mmu_en      (mmu_en),
      .tbl_wr_en   (tbl_wr_en),
      .tbl_wr_addr (tbl_wr_addr),
      .tbl_wr_data (tbl_wr_data)
   );

   memory_dp #(.MAW(MAW)) u_table (
      .clk         (clk),
      .wr_en       (tbl_wr_en),
      .wr_addr     (tbl_wr_addr),
      .wr_data     (tbl_wr_data),
      .rd_en       (tbl_rd_en),
      .rd_addr     (tbl_rd_addr),
      .rd_data     (tbl_rd_data)
   );

   emmu #(.MAW(MAW)) u_emmu (
      .clk                 (clk),
      .reset               (reset),
      .mmu_en              (mmu_en),
      .mmu_bp              (mmu_bp),
      .emesh_access_in     (emesh_access_in),
      .emesh_packet_in     (emesh_packet_in),
      .emesh_wait_in       (emesh_wait_in),
      .tbl_rd_data         (tbl_rd_data),
      .tbl_rd_en           (tbl_rd_en),
      .tbl_rd_addr         (tbl_rd_addr),
      .emesh_access_out    (emesh_access_out),
      .emesh_packet_out    (emesh_packet_out),
      .emesh_packet_hi_out (emesh_packet_hi_out)
   );

endmodule

// ==== memory_dp.sv ====
`timescale 1ns/10ps

// simple dual port table ram
// one byte enabled write port and one registered read port, same clock
module memory_dp #(
   parameter int MAW = 12                        // entries = 2**MAW
) (
   input  logic                      clk,
   input  logic [5:0]                wr_en,      // one enable per byte
   input  logic [MAW-1:0]            wr_addr,
   input  logic [emmu_pkg::MW-1:0]   wr_data,
   input  logic                      rd_en,      // read register update
   input  logic [MAW-1:0]            rd_addr,
   output logic [emmu_pkg::MW-1:0]   rd_data
);

   localparam int DEPTH = 2**MAW;

   logic [emmu_pkg::MW-1:0] mem [0:DEPTH-1];     // no reset, cleared by scrub

   // write lands at the clock edge, byte lanes independent
   always_ff @(posedge clk) begin
      for (int i = 0; i < 6; i++) begin
         if (wr_en[i])
            mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
      end
   end

   // registered read, holds while rd_en is low
   always_ff @(posedge clk) begin
      if (rd_en)
         rd_data <= mem[rd_addr];
   end

   // an x on a byte enable would corrupt an unknown entry
   a_wr_en_known : assert property (
      @(posedge clk) !$isunknown(wr_en)
   ) else $error("memory_dp: write enable unknown");

endmodule

// ==== tb.f ====
emmu_pkg.sv
memory_dp.sv
emmu_scrub.sv
emmu_cfg.sv
emmu.sv
emmu_top.sv
emmu_tb.sv
